//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    localparam int REG_ID_W = 5;
    typedef logic [REG_ID_W-1:0] reg_id_t;

    // major opcode field, inst[6:0]
    localparam int OP_TYPE_W = 7;
    typedef logic [OP_TYPE_W-1:0] op_type_t;

    localparam op_type_t OP_LUI    = 7'b0110111;
    localparam op_type_t OP_AUIPC  = 7'b0010111;
    localparam op_type_t OP_JAL    = 7'b1101111;
    localparam op_type_t OP_JALR   = 7'b1100111;
    localparam op_type_t OP_BRANCH = 7'b1100011;
    localparam op_type_t OP_STORE  = 7'b0100011;
    localparam op_type_t OP_LOAD   = 7'b0000011;
    localparam op_type_t OP_IMM    = 7'b0010011; // alu with immediate
    localparam op_type_t OP_REG    = 7'b0110011; // alu reg-reg

endpackage

`default_nettype wire

//--- hw/rob_cfg_pkg.sv
`default_nettype none

package rob_cfg_pkg;

    // must stay a power of two, pointers wrap naturally
    localparam int ROB_SIZE = 8;

    localparam int ROB_IDX_W = $clog2(ROB_SIZE);
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // one extra bit so a full buffer is distinct from empty
    localparam int ROB_CNT_W = ROB_IDX_W + 1;
    typedef logic [ROB_CNT_W-1:0] rob_cnt_t;

endpackage

`default_nettype wire

//--- hw/rob_alloc.sv
`default_nettype none

module rob_alloc (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          rdy_in,
    input  logic                          inst_valid,
    input  rv_isa_pkg::word_t             inst_pc,
    input  rv_isa_pkg::word_t             imm,
    input  rv_isa_pkg::reg_id_t           rd_id,
    input  rv_isa_pkg::op_type_t          op_type,
    input  logic                          br_pred,
    input  logic                          retire_fire,
    input  logic                          flush,
    output logic [rob_cfg_pkg::ROB_SIZE-1:0] alloc_sel,
    output rv_isa_pkg::word_t             alloc_pc,
    output rv_isa_pkg::word_t             alloc_imm,
    output rv_isa_pkg::reg_id_t           alloc_rd,
    output logic                          alloc_is_branch,
    output logic                          alloc_pred,
    output logic                          alloc_writes_rd,
    output logic                          alloc_ready,
    output rv_isa_pkg::word_t             alloc_value,
    output logic                          issue_valid,
    output rv_isa_pkg::reg_id_t           issue_rd,
    output rob_cfg_pkg::rob_idx_t         issue_tag,
    output logic                          rob_full,
    output logic                          rob_empty
);
    import rv_isa_pkg::*;
    import rob_cfg_pkg::*;

    rob_idx_t tail;
    rob_cnt_t count;
    logic     accept;

    // an issue in the flush cycle is on the wrong path
    assign accept = inst_valid && rdy_in && !flush;

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            tail  <= '0;
            count <= '0;
        end else if (rdy_in) begin
            if (accept) begin
                tail <= tail + 1'b1;
            end
            case ({accept, retire_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none, or one in and one out
            endcase
        end
    end

    assign rob_full  = (count == rob_cnt_t'(ROB_SIZE));
    assign rob_empty = (count == '0);

    assign alloc_sel = accept ? (ROB_SIZE'(1) << tail) : '0;

    // rename sees the tag before the edge
    assign issue_valid = accept;
    assign issue_rd    = rd_id;
    assign issue_tag   = tail;

    assign alloc_pc        = inst_pc;
    assign alloc_imm       = imm;
    assign alloc_rd        = rd_id;
    assign alloc_pred      = br_pred;
    assign alloc_is_branch = (op_type == OP_BRANCH);
    assign alloc_writes_rd = (op_type != OP_BRANCH) && (op_type != OP_STORE);

    // ops whose result is known at decode
    always_comb begin
        case (op_type)
            OP_LUI: begin
                alloc_ready = 1'b1;
                alloc_value = imm;
            end
            OP_AUIPC: begin
                alloc_ready = 1'b1;
                alloc_value = inst_pc + imm;
            end
            OP_JAL, OP_JALR: begin
                alloc_ready = 1'b1;
                alloc_value = inst_pc + 32'd4; // link address
            end
            default: begin
                alloc_ready = 1'b0;            // wait for a broadcast
                alloc_value = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rob_slot.sv
`default_nettype none

module rob_slot #(
    parameter rob_cfg_pkg::rob_idx_t SLOT_ID = '0
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  rdy_in,
    input  logic                  alloc_en,
    input  rv_isa_pkg::word_t     alloc_pc,
    input  rv_isa_pkg::word_t     alloc_imm,
    input  rv_isa_pkg::reg_id_t   alloc_rd,
    input  logic                  alloc_is_branch,
    input  logic                  alloc_pred,
    input  logic                  alloc_writes_rd,
    input  logic                  alloc_ready,
    input  rv_isa_pkg::word_t     alloc_value,
    input  logic                  cdb0_valid,
    input  rob_cfg_pkg::rob_idx_t cdb0_tag,
    input  rv_isa_pkg::word_t     cdb0_value,
    input  logic                  cdb1_valid,
    input  rob_cfg_pkg::rob_idx_t cdb1_tag,
    input  rv_isa_pkg::word_t     cdb1_value,
    input  logic                  free_en,
    input  logic                  flush,
    output logic                  busy,
    output logic                  ready,
    output rv_isa_pkg::word_t     value,
    output rv_isa_pkg::word_t     pc,
    output rv_isa_pkg::word_t     imm,
    output rv_isa_pkg::reg_id_t   rd,
    output logic                  is_branch,
    output logic                  pred,
    output logic                  writes_rd
);
    import rv_isa_pkg::*;
    import rob_cfg_pkg::*;

    logic  cdb0_hit;
    logic  cdb1_hit;
    logic  capture;
    word_t cdb_value;

    assign cdb0_hit = cdb0_valid && (cdb0_tag == SLOT_ID);
    assign cdb1_hit = cdb1_valid && (cdb1_tag == SLOT_ID);
    assign capture  = busy && (cdb0_hit || cdb1_hit);

    // the buses never share a tag, so the order here is arbitrary
    assign cdb_value = cdb0_hit ? cdb0_value : cdb1_value;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy  <= 1'b0;
            ready <= 1'b0;
        end else if (rdy_in) begin
            if (flush || free_en) begin
                busy  <= 1'b0;
                ready <= 1'b0;
            end else if (alloc_en) begin
                busy  <= 1'b1;
                ready <= alloc_ready;
            end else if (capture) begin
                ready <= 1'b1;
            end
        end
    end

    // payload only meaningful while busy
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (alloc_en) begin
                pc        <= alloc_pc;
                imm       <= alloc_imm;
                rd        <= alloc_rd;
                is_branch <= alloc_is_branch;
                pred      <= alloc_pred;
                writes_rd <= alloc_writes_rd;
                value     <= alloc_value;
            end else if (capture) begin
                value <= cdb_value;       // branch outcome lands in bit 0
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rob_retire.sv
`default_nettype none

module rob_retire (
    input  logic                                              clk_in,
    input  logic                                              rst_in,
    input  logic                                              rdy_in,
    input  logic [rob_cfg_pkg::ROB_SIZE-1:0]                  slot_busy,
    input  logic [rob_cfg_pkg::ROB_SIZE-1:0]                  slot_ready,
    input  rv_isa_pkg::word_t [rob_cfg_pkg::ROB_SIZE-1:0]     slot_value,
    input  rv_isa_pkg::word_t [rob_cfg_pkg::ROB_SIZE-1:0]     slot_pc,
    input  rv_isa_pkg::word_t [rob_cfg_pkg::ROB_SIZE-1:0]     slot_imm,
    input  rv_isa_pkg::reg_id_t [rob_cfg_pkg::ROB_SIZE-1:0]   slot_rd,
    input  logic [rob_cfg_pkg::ROB_SIZE-1:0]                  slot_is_branch,
    input  logic [rob_cfg_pkg::ROB_SIZE-1:0]                  slot_pred,
    input  logic [rob_cfg_pkg::ROB_SIZE-1:0]                  slot_writes_rd,
    output logic                                              retire_fire,
    output logic [rob_cfg_pkg::ROB_SIZE-1:0]                  free_sel,
    output logic                                              flush,
    output rv_isa_pkg::word_t                                 next_pc,
    output logic                                              commit_valid,
    output logic                                              commit_write,
    output rv_isa_pkg::reg_id_t                               commit_rd,
    output rob_cfg_pkg::rob_idx_t                             commit_tag,
    output rv_isa_pkg::word_t                                 commit_value
);
    import rv_isa_pkg::*;
    import rob_cfg_pkg::*;

    rob_idx_t head;
    word_t    head_pc;
    word_t    head_imm;
    logic     taken;

    assign head_pc  = slot_pc[head];
    assign head_imm = slot_imm[head];
    assign taken    = slot_value[head][0];

    assign retire_fire = rdy_in && slot_busy[head] && slot_ready[head];
    assign free_sel    = retire_fire ? (ROB_SIZE'(1) << head) : '0;

    assign commit_valid = retire_fire;
    assign commit_write = retire_fire && slot_writes_rd[head];
    assign commit_rd    = slot_rd[head];
    assign commit_tag   = head;
    assign commit_value = slot_value[head];

    // mispredict only seen once the branch reaches the head
    assign flush   = retire_fire && slot_is_branch[head] && (taken != slot_pred[head]);
    assign next_pc = taken ? head_pc + head_imm : head_pc + 32'd4;

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            head <= '0;             // matches tail reset in the allocator
        end else if (retire_fire) begin
            head <= head + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/rob_operand_read.sv
`default_nettype none

module rob_operand_read (
    input  logic [rob_cfg_pkg::ROB_SIZE-1:0]              slot_ready,
    input  rv_isa_pkg::word_t [rob_cfg_pkg::ROB_SIZE-1:0] slot_value,
    input  logic                                          cdb0_valid,
    input  rob_cfg_pkg::rob_idx_t                         cdb0_tag,
    input  rv_isa_pkg::word_t                             cdb0_value,
    input  logic                                          cdb1_valid,
    input  rob_cfg_pkg::rob_idx_t                         cdb1_tag,
    input  rv_isa_pkg::word_t                             cdb1_value,
    input  rob_cfg_pkg::rob_idx_t                         query1_tag,
    input  rob_cfg_pkg::rob_idx_t                         query2_tag,
    output logic                                          query1_ready,
    output rv_isa_pkg::word_t                             query1_value,
    output logic                                          query2_ready,
    output rv_isa_pkg::word_t                             query2_value
);
    import rv_isa_pkg::*;
    import rob_cfg_pkg::*;

    // returns {ready, value} for one tag
    function automatic logic [XLEN:0] lookup(input rob_idx_t tag);
        logic [XLEN:0] res;
        if (slot_ready[tag]) begin
            res = {1'b1, slot_value[tag]};
        end else if (cdb0_valid && cdb0_tag == tag) begin
            res = {1'b1, cdb0_value};      // same-cycle bypass
        end else if (cdb1_valid && cdb1_tag == tag) begin
            res = {1'b1, cdb1_value};
        end else begin
            res = '0;
        end
        return res;
    endfunction

    always_comb begin
        {query1_ready, query1_value} = lookup(query1_tag);
        {query2_ready, query2_value} = lookup(query2_tag);
    end

endmodule

`default_nettype wire

//--- hw/rob_top.sv
`default_nettype none

module rob_top (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  rdy_in,
    input  logic                  inst_valid,
    input  rv_isa_pkg::word_t     inst_pc,
    input  rv_isa_pkg::word_t     imm,
    input  rv_isa_pkg::reg_id_t   rd_id,
    input  rv_isa_pkg::op_type_t  op_type,
    input  logic                  br_pred,
    output logic                  rob_full,
    output logic                  rob_empty,
    output logic                  issue_valid,
    output rv_isa_pkg::reg_id_t   issue_rd,
    output rob_cfg_pkg::rob_idx_t issue_tag,
    input  logic                  cdb0_valid,
    input  rob_cfg_pkg::rob_idx_t cdb0_tag,
    input  rv_isa_pkg::word_t     cdb0_value,
    input  logic                  cdb1_valid,
    input  rob_cfg_pkg::rob_idx_t cdb1_tag,
    input  rv_isa_pkg::word_t     cdb1_value,
    output logic                  commit_valid,
    output logic                  commit_write,
    output rv_isa_pkg::reg_id_t   commit_rd,
    output rob_cfg_pkg::rob_idx_t commit_tag,
    output rv_isa_pkg::word_t     commit_value,
    output logic                  flush,
    output rv_isa_pkg::word_t     next_pc,
    input  rob_cfg_pkg::rob_idx_t query1_tag,
    output logic                  query1_ready,
    output rv_isa_pkg::word_t     query1_value,
    input  rob_cfg_pkg::rob_idx_t query2_tag,
    output logic                  query2_ready,
    output rv_isa_pkg::word_t     query2_value
);
    import rv_isa_pkg::*;
    import rob_cfg_pkg::*;

    // shared allocation fields
    logic [ROB_SIZE-1:0] alloc_sel;
    word_t               alloc_pc;
    word_t               alloc_imm;
    reg_id_t             alloc_rd;
    logic                alloc_is_branch;
    logic                alloc_pred;
    logic                alloc_writes_rd;
    logic                alloc_ready;
    word_t               alloc_value;

    logic                retire_fire;
    logic [ROB_SIZE-1:0] free_sel;

    // per-slot state, index is the tag
    logic [ROB_SIZE-1:0]    slot_busy;
    logic [ROB_SIZE-1:0]    slot_ready;
    word_t [ROB_SIZE-1:0]   slot_value;
    word_t [ROB_SIZE-1:0]   slot_pc;
    word_t [ROB_SIZE-1:0]   slot_imm;
    reg_id_t [ROB_SIZE-1:0] slot_rd;
    logic [ROB_SIZE-1:0]    slot_is_branch;
    logic [ROB_SIZE-1:0]    slot_pred;
    logic [ROB_SIZE-1:0]    slot_writes_rd;

    rob_alloc u_alloc (
        .clk_in, .rst_in, .rdy_in,
        .inst_valid, .inst_pc, .imm, .rd_id, .op_type, .br_pred,
        .retire_fire, .flush,
        .alloc_sel, .alloc_pc, .alloc_imm, .alloc_rd,
        .alloc_is_branch, .alloc_pred, .alloc_writes_rd,
        .alloc_ready, .alloc_value,
        .issue_valid, .issue_rd, .issue_tag,
        .rob_full, .rob_empty
    );

    for (genvar i = 0; i < ROB_SIZE; i++) begin : g_slot
        rob_slot #(
            .SLOT_ID(rob_idx_t'(i))
        ) u_slot (
            .clk_in, .rst_in, .rdy_in,
            .alloc_en        (alloc_sel[i]),
            .alloc_pc, .alloc_imm, .alloc_rd,
            .alloc_is_branch, .alloc_pred, .alloc_writes_rd,
            .alloc_ready, .alloc_value,
            .cdb0_valid, .cdb0_tag, .cdb0_value,
            .cdb1_valid, .cdb1_tag, .cdb1_value,
            .free_en         (free_sel[i]),
            .flush,
            .busy            (slot_busy[i]),
            .ready           (slot_ready[i]),
            .value           (slot_value[i]),
            .pc              (slot_pc[i]),
            .imm             (slot_imm[i]),
            .rd              (slot_rd[i]),
            .is_branch       (slot_is_branch[i]),
            .pred            (slot_pred[i]),
            .writes_rd       (slot_writes_rd[i])
        );
    end

    rob_retire u_retire (
        .clk_in, .rst_in, .rdy_in,
        .slot_busy, .slot_ready, .slot_value, .slot_pc, .slot_imm,
        .slot_rd, .slot_is_branch, .slot_pred, .slot_writes_rd,
        .retire_fire, .free_sel, .flush, .next_pc,
        .commit_valid, .commit_write, .commit_rd, .commit_tag, .commit_value
    );

    rob_operand_read u_read (
        .slot_ready, .slot_value,
        .cdb0_valid, .cdb0_tag, .cdb0_value,
        .cdb1_valid, .cdb1_tag, .cdb1_value,
        .query1_tag, .query2_tag,
        .query1_ready, .query1_value,
        .query2_ready, .query2_value
    );

endmodule

`default_nettype wire

//--- sim/rob_tb.sv
`default_nettype none

module rob_tb;
    import rv_isa_pkg::*;
    import rob_cfg_pkg::*;

    localparam int CYCLES_PER_TEST = 400;
    localparam int NUM_TESTS       = 6;
    localparam int COMMIT_WAIT     = 40;  // cycles allowed for expected commits

    logic     clk_in = 1'b0;
    logic     rst_in;
    logic     rdy_in;
    logic     inst_valid;
    word_t    inst_pc;
    word_t    imm;
    reg_id_t  rd_id;
    op_type_t op_type;
    logic     br_pred;
    logic     rob_full;
    logic     rob_empty;
    logic     issue_valid;
    reg_id_t  issue_rd;
    rob_idx_t issue_tag;
    logic     cdb0_valid;
    rob_idx_t cdb0_tag;
    word_t    cdb0_value;
    logic     cdb1_valid;
    rob_idx_t cdb1_tag;
    word_t    cdb1_value;
    logic     commit_valid;
    logic     commit_write;
    reg_id_t  commit_rd;
    rob_idx_t commit_tag;
    word_t    commit_value;
    logic     flush;
    word_t    next_pc;
    rob_idx_t query1_tag;
    logic     query1_ready;
    word_t    query1_value;
    rob_idx_t query2_tag;
    logic     query2_ready;
    word_t    query2_value;

    // reference model indexed by tag
    word_t    m_value  [ROB_SIZE];
    word_t    m_pc     [ROB_SIZE];
    word_t    m_imm    [ROB_SIZE];
    reg_id_t  m_rd     [ROB_SIZE];
    logic     m_write  [ROB_SIZE];
    logic     m_ready  [ROB_SIZE];
    logic     m_branch [ROB_SIZE];
    logic     m_pred   [ROB_SIZE];
    rob_idx_t order_q  [$];          // tags in program order
    rob_idx_t model_tail;
    int       commit_count;
    string    test_name;
    logic [15:0] lfsr_state;

    rob_top uut (.*);

    always #50 clk_in = ~clk_in;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int nbits, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: test %s, %s", test_name, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: test %s, %s: expected %08h, actual %08h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #10;
    endtask

    task automatic issue_op(input op_type_t op, input word_t pc, input word_t imm_val,
                            input reg_id_t rd, input logic pred);
        rob_idx_t tag;
        tag        = model_tail;
        inst_valid = 1'b1;
        inst_pc    = pc;
        imm        = imm_val;
        rd_id      = rd;
        op_type    = op;
        br_pred    = pred;
        #5;
        check_equal("issue_valid", 1, issue_valid);
        check_equal("issue_tag", tag, issue_tag);
        check_equal("issue_rd", rd, issue_rd);
        m_pc[tag]     = pc;
        m_imm[tag]    = imm_val;
        m_rd[tag]     = rd;
        m_pred[tag]   = pred;
        m_branch[tag] = (op == OP_BRANCH);
        m_write[tag]  = (op != OP_BRANCH) && (op != OP_STORE);
        case (op)
            OP_LUI:          {m_ready[tag], m_value[tag]} = {1'b1, imm_val};
            OP_AUIPC:        {m_ready[tag], m_value[tag]} = {1'b1, pc + imm_val};
            OP_JAL, OP_JALR: {m_ready[tag], m_value[tag]} = {1'b1, pc + 32'd4};
            default:         {m_ready[tag], m_value[tag]} = {1'b0, 32'd0};
        endcase
        order_q.push_back(tag);
        model_tail = tag + 1'b1;
        next_cycle();
        inst_valid = 1'b0;
    endtask

    task automatic start_broadcast(input int bus, input rob_idx_t tag, input word_t value);
        if (bus == 0) begin
            cdb0_valid = 1'b1;
            cdb0_tag   = tag;
            cdb0_value = value;
        end else begin
            cdb1_valid = 1'b1;
            cdb1_tag   = tag;
            cdb1_value = value;
        end
        m_value[tag] = value;
        m_ready[tag] = 1'b1;
    endtask

    task automatic end_broadcast();
        next_cycle();
        cdb0_valid = 1'b0;
        cdb1_valid = 1'b0;
    endtask

    task automatic complete(input int bus, input rob_idx_t tag, input word_t value);
        start_broadcast(bus, tag, value);
        end_broadcast();
    endtask

    task automatic wait_commits(input int target);
        int waited;
        waited = 0;
        while (commit_count < target) begin
            if (waited == COMMIT_WAIT) begin
                report_failure("expected commits did not arrive in time");
            end
            next_cycle();
            waited++;
        end
    endtask

    // commit outputs are stable mid-cycle
    always @(negedge clk_in) begin : commit_monitor
        rob_idx_t tag;
        logic     taken;
        logic     exp_flush;
        exp_flush = 1'b0;
        if (!rst_in) begin
            if (commit_valid) begin
                if (order_q.size() == 0) begin
                    report_failure("commit seen with no entry pending");
                end
                tag = order_q.pop_front();
                if (!m_ready[tag]) begin
                    report_failure("commit of an entry that was never completed");
                end
                check_equal("commit_tag", tag, commit_tag);
                check_equal("commit_write", m_write[tag], commit_write);
                if (m_write[tag]) begin
                    check_equal("commit_rd", m_rd[tag], commit_rd);
                end
                check_equal("commit_value", m_value[tag], commit_value);
                if (m_branch[tag]) begin
                    taken     = m_value[tag][0];  // outcome bit
                    exp_flush = (taken != m_pred[tag]);
                    if (exp_flush) begin
                        check_equal("next_pc", taken ? m_pc[tag] + m_imm[tag] : m_pc[tag] + 4,
                                    next_pc);
                    end
                end
                commit_count++;
            end
            check_equal("flush", exp_flush, flush);
            if (flush) begin
                order_q.delete();     // younger entries are squashed
            end
        end
    end

    initial begin : watchdog
        repeat (CYCLES_PER_TEST * NUM_TESTS) @(posedge clk_in);
        $display("ERROR: the run timed out after %0d cycles", CYCLES_PER_TEST * NUM_TESTS);
        $display("TEST FAILED");
        $fatal(1);
    end

    task automatic reset_state();
        test_name = "reset_state";
        check_equal("rob_empty", 1, rob_empty);
        check_equal("rob_full", 0, rob_full);
        check_equal("commit_valid", 0, commit_valid);
        check_equal("flush", 0, flush);
        check_equal("issue_valid", 0, issue_valid);
    endtask

    task automatic immediate_ops();
        int base;
        test_name = "immediate_ops";
        base = commit_count;
        check_equal("first tag", 0, issue_tag);
        issue_op(OP_LUI, 32'h0000_1000, 32'hABCD_E000, 5'd5, 1'b0);
        check_equal("lui one cycle latency", 1, commit_valid);
        issue_op(OP_AUIPC, 32'h0000_1004, 32'h0001_2000, 5'd6, 1'b0);
        issue_op(OP_JAL, 32'h0000_1008, 32'h0000_0100, 5'd1, 1'b0);
        wait_commits(base + 3);
    endtask

    task automatic out_of_order_completion();
        op_type_t    ops [5];
        rob_idx_t    tags [5];
        logic [31:0] r;
        int          base;
        test_name = "out_of_order_completion";
        base = commit_count;
        ops = '{OP_REG, OP_LOAD, OP_REG, OP_LOAD, OP_STORE};
        for (int i = 0; i < 5; i++) begin
            tags[i] = model_tail;
            draw_bits(5, r);
            issue_op(ops[i], 32'h0000_2000 + 4 * i, 32'd0, r[4:0], 1'b0);
        end
        for (int i = 4; i >= 0; i--) begin
            draw_bits(32, r);
            complete((ops[i] == OP_REG) ? 0 : 1, tags[i], r);  // alu on bus 0
        end
        wait_commits(base + 5);
    endtask

    task automatic read_port_bypass();
        rob_idx_t    tag_a;
        rob_idx_t    tag_b;
        logic [31:0] va;
        logic [31:0] vb;
        int          base;
        test_name = "read_port_bypass";
        base  = commit_count;
        tag_a = model_tail;
        issue_op(OP_REG, 32'h0000_3000, 32'd0, 5'd7, 1'b0);
        tag_b = model_tail;
        issue_op(OP_LOAD, 32'h0000_3004, 32'd0, 5'd8, 1'b0);
        query1_tag = tag_a;
        query2_tag = tag_b;
        #5;
        check_equal("pending q1 ready", 0, query1_ready);
        check_equal("pending q1 value", 0, query1_value);
        check_equal("pending q2 ready", 0, query2_ready);
        next_cycle();
        draw_bits(32, va);
        draw_bits(32, vb);
        start_broadcast(0, tag_a, va);
        #5;
        check_equal("bypass q1 ready", 1, query1_ready);
        check_equal("bypass q1 value", va, query1_value);
        check_equal("bypass q2 ready", 0, query2_ready);
        end_broadcast();
        check_equal("stored q1 ready", 1, query1_ready);
        check_equal("stored q1 value", va, query1_value);
        next_cycle();
        start_broadcast(1, tag_b, vb);
        #5;
        check_equal("bypass q2 ready", 1, query2_ready);
        check_equal("bypass q2 value", vb, query2_value);
        end_broadcast();
        wait_commits(base + 2);
    endtask

    task automatic full_and_stall();
        rob_idx_t    tags [ROB_SIZE];
        logic [31:0] r;
        int          base;
        test_name = "full_and_stall";
        base = commit_count;
        for (int i = 0; i < ROB_SIZE; i++) begin
            check_equal("not full while filling", 0, rob_full);
            tags[i] = model_tail;
            issue_op(OP_REG, 32'h0000_4000 + 4 * i, 32'd0, 5'(i + 10), 1'b0);
        end
        check_equal("rob_full", 1, rob_full);
        draw_bits(32, r);
        complete(0, tags[0], r);
        rdy_in = 1'b0;             // head is ready but frozen
        repeat (3) begin
            #5;
            check_equal("commit while stalled", 0, commit_valid);
            check_equal("full while stalled", 1, rob_full);
            next_cycle();
        end
        rdy_in = 1'b1;
        #5;
        check_equal("commit after stall", 1, commit_valid);
        next_cycle();
        check_equal("rob_full after commit", 0, rob_full);
        for (int i = ROB_SIZE - 1; i >= 1; i--) begin
            draw_bits(32, r);
            complete(i % 2, tags[i], r);
        end
        wait_commits(base + ROB_SIZE);
    endtask

    task automatic mispredict(input word_t pc, input word_t offset, input logic pred);
        rob_idx_t    br_tag;
        logic [31:0] r;
        int          base;
        base    = commit_count;
        br_tag  = model_tail;
        issue_op(OP_BRANCH, pc, offset, 5'd0, pred);
        issue_op(OP_LUI, pc + 4, 32'h1234_5000, 5'd3, 1'b0);  // ready but younger
        issue_op(OP_REG, pc + 8, 32'd0, 5'd4, 1'b0);
        draw_bits(32, r);
        complete(0, br_tag, {r[31:1], ~pred});
        wait_commits(base + 1);
        check_equal("rob_empty after flush", 1, rob_empty);
        check_equal("commit after flush", 0, commit_valid);
        model_tail = '0;
        repeat (3) next_cycle();
    endtask

    task automatic branch_resolution();
        rob_idx_t    br_tag;
        logic [31:0] r;
        int          base;
        test_name = "branch_resolution";
        base   = commit_count;
        br_tag = model_tail;
        issue_op(OP_BRANCH, 32'h0000_5000, 32'h0000_0040, 5'd0, 1'b1);
        draw_bits(32, r);
        complete(0, br_tag, {r[31:1], 1'b1});  // taken as predicted
        wait_commits(base + 1);
        mispredict(32'h0000_6000, 32'h0000_0080, 1'b0);
        mispredict(32'h0000_7000, 32'hFFFF_FF00, 1'b1);
    endtask

    initial begin
        rst_in       = 1'b1;
        rdy_in       = 1'b1;
        inst_valid   = 1'b0;
        inst_pc      = '0;
        imm          = '0;
        rd_id        = '0;
        op_type      = OP_IMM;
        br_pred      = 1'b0;
        cdb0_valid   = 1'b0;
        cdb0_tag     = '0;
        cdb0_value   = '0;
        cdb1_valid   = 1'b0;
        cdb1_tag     = '0;
        cdb1_value   = '0;
        query1_tag   = '0;
        query2_tag   = '0;
        model_tail   = '0;
        commit_count = 0;
        test_name    = "setup";
        lfsr_state   = 16'd25707;
        repeat (3) @(posedge clk_in);
        #10;
        rst_in = 1'b0;

        reset_state();
        immediate_ops();
        out_of_order_completion();
        read_port_bypass();
        full_and_stall();
        branch_resolution();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/rv_isa_pkg.sv
hw/rob_cfg_pkg.sv
hw/rob_alloc.sv
hw/rob_slot.sv
hw/rob_retire.sv
hw/rob_operand_read.sv
hw/rob_top.sv
sim/rob_tb.sv

//--- Makefile
# Verilator flow for the reorder buffer
# override on the command line, e.g. make sim BUILD_DIR=out LOG=run.log

VERILATOR ?= verilator
TOP       ?= rob_tb
RTL_TOP   ?= rob_top
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= verilog.f

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
